// ==== rtl/rmii_pkg.sv ====
`default_nettype none

package rmii_pkg;

    localparam int DIBIT_W = 2;
    localparam int BYTE_W  = 8;
    localparam int WORD_W  = BYTE_W + 1;

    // Bit 8 flags the final byte of a frame
    typedef logic [WORD_W-1:0] word_t;

    ////////////////////
    // Ethernet framing
    ////////////////////
    localparam logic [BYTE_W-1:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [BYTE_W-1:0] SFD_BYTE      = 8'hD5;

    localparam int PREAMBLE_BYTES = 7;
    localparam int IFG_BYTES      = 12;
    localparam int FCS_BYTES      = 4;

    localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
    // Residue in MSB-first bit order
    localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

    // Reflected CRC-32, data taken LSB first
    function automatic logic [31:0] crc32_next(input logic [31:0] crc,
                                               input logic [BYTE_W-1:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < BYTE_W; i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ 32'hEDB8_8320;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/rmii_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rmii_byte_if;
    import rmii_pkg::*;

    logic [BYTE_W-1:0] data;
    logic              valid;
    logic              last;
    logic              error;

    modport source (
        output data, valid, last, error
    );

    modport sink (
        input data, valid, last, error
    );

endinterface

`default_nettype wire

// ==== rtl/rmii_byte_packager.sv ====
`timescale 1ns/1ps
`default_nettype none

module rmii_byte_packager (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire [rmii_pkg::DIBIT_W-1:0] rmii_receive_data,
    input  wire                         rmii_receive_data_enable,
    input  wire                         rmii_receive_data_error,
    rmii_byte_if.source                 byte_out
);
    import rmii_pkg::*;

    logic              in_frame;
    logic              saw_preamble;
    logic [1:0]        dibit_count;
    logic [BYTE_W-1:0] shift_q;
    logic [BYTE_W-1:0] pending_q;
    logic              pending_valid;
    logic              error_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            in_frame       <= 1'b0;
            saw_preamble   <= 1'b0;
            dibit_count    <= '0;
            pending_valid  <= 1'b0;
            error_q        <= 1'b0;
            byte_out.valid <= 1'b0;
            byte_out.last  <= 1'b0;
            byte_out.error <= 1'b0;
        end else begin
            byte_out.valid <= 1'b0;
            byte_out.last  <= 1'b0;
            byte_out.error <= 1'b0;
            if (!in_frame) begin
                // Hunt for the 01 ... 11 end of the delimiter
                dibit_count   <= '0;
                pending_valid <= 1'b0;
                error_q       <= 1'b0;
                if (rmii_receive_data_enable && rmii_receive_data == 2'b11 && saw_preamble)
                    in_frame <= 1'b1;
                saw_preamble <= rmii_receive_data_enable && rmii_receive_data == 2'b01;
            end else if (rmii_receive_data_enable) begin
                shift_q     <= {rmii_receive_data, shift_q[BYTE_W-1:DIBIT_W]};
                dibit_count <= dibit_count + 1'b1;
                if (rmii_receive_data_error)
                    error_q <= 1'b1;
                if (dibit_count == 2'd3) begin
                    pending_q     <= {rmii_receive_data, shift_q[BYTE_W-1:DIBIT_W]};
                    pending_valid <= 1'b1;
                end
                // Previous byte is not the last one, release it
                if (pending_valid) begin
                    byte_out.valid <= 1'b1;
                    byte_out.data  <= pending_q;
                    pending_valid  <= 1'b0;
                end
            end else begin
                in_frame     <= 1'b0;
                saw_preamble <= 1'b0;
                if (pending_valid || dibit_count != 2'd0) begin
                    byte_out.valid <= 1'b1;
                    byte_out.last  <= 1'b1;
                    byte_out.data  <= pending_valid ? pending_q : shift_q;
                    byte_out.error <= error_q || dibit_count != 2'd0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_checker (
    input  wire             clock,
    input  wire             rst_n,
    rmii_byte_if.sink       byte_in,
    input  wire             full,
    output rmii_pkg::word_t write_data,
    output logic            write_enable,
    output logic            commit,
    output logic            discard
);
    import rmii_pkg::*;

    localparam int COUNT_W = $clog2(FCS_BYTES + 1);

    logic [BYTE_W-1:0]  delay_q [FCS_BYTES];
    logic [COUNT_W-1:0] count_q;
    logic [31:0]        crc_q;
    logic [31:0]        crc_next;
    logic [31:0]        crc_reversed;
    logic               overflow_q;
    logic               take;
    logic               frame_good;

    assign crc_next     = crc32_next(crc_q, byte_in.data);
    assign crc_reversed = {<<{crc_next}};

    // Oldest byte leaves once the delay line is full
    assign take = byte_in.valid && count_q == COUNT_W'(FCS_BYTES);

    assign frame_good = take && !full && !overflow_q && !byte_in.error &&
                        crc_reversed == CRC_RESIDUE;

    ////////////////////
    // FCS delay line
    ////////////////////
    always_ff @(posedge clock) begin
        if (byte_in.valid) begin
            delay_q[0] <= byte_in.data;
            for (int i = 1; i < FCS_BYTES; i++) begin
                delay_q[i] <= delay_q[i-1];
            end
        end
        write_data <= {byte_in.last, delay_q[FCS_BYTES-1]};
    end

    ////////////////////
    // CRC and decision
    ////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            crc_q        <= CRC_INIT;
            count_q      <= '0;
            overflow_q   <= 1'b0;
            write_enable <= 1'b0;
            commit       <= 1'b0;
            discard      <= 1'b0;
        end else begin
            write_enable <= take;
            commit       <= 1'b0;
            discard      <= 1'b0;
            if (take && full)
                overflow_q <= 1'b1;
            if (byte_in.valid) begin
                if (byte_in.last) begin
                    crc_q      <= CRC_INIT;
                    count_q    <= '0;
                    overflow_q <= 1'b0;
                    commit     <= frame_good;
                    discard    <= !frame_good;
                end else begin
                    crc_q <= crc_next;
                    if (count_q != COUNT_W'(FCS_BYTES))
                        count_q <= count_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int DEPTH = 64
) (
    input  wire             clock,
    input  wire             rst_n,
    input  rmii_pkg::word_t write_data,
    input  wire             write_enable,
    input  wire             commit,
    input  wire             discard,
    output logic            full,
    input  wire             read_enable,
    output rmii_pkg::word_t read_data,
    output logic            read_data_valid
);
    import rmii_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    word_t       mem [DEPTH];
    logic [ADDR_W:0] write_ptr;
    logic [ADDR_W:0] commit_ptr;
    logic [ADDR_W:0] read_ptr;
    logic            do_write;
    logic            load;

    assign full = write_ptr[ADDR_W] != read_ptr[ADDR_W] &&
                  write_ptr[ADDR_W-1:0] == read_ptr[ADDR_W-1:0];
    assign do_write = write_enable && !full;

    // Output register refills while it is empty or being popped
    assign load = commit_ptr != read_ptr && (!read_data_valid || read_enable);

    always_ff @(posedge clock) begin
        if (do_write)
            mem[write_ptr[ADDR_W-1:0]] <= write_data;
        if (load)
            read_data <= mem[read_ptr[ADDR_W-1:0]];
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            write_ptr       <= '0;
            commit_ptr      <= '0;
            read_ptr        <= '0;
            read_data_valid <= 1'b0;
        end else begin
            // Rewind drops the whole tentative frame
            if (discard)
                write_ptr <= commit_ptr;
            else if (do_write)
                write_ptr <= write_ptr + 1'b1;
            // Final word may land in the commit cycle
            if (commit)
                commit_ptr <= do_write ? write_ptr + 1'b1 : write_ptr;
            if (load) begin
                read_ptr        <= read_ptr + 1'b1;
                read_data_valid <= 1'b1;
            end else if (read_enable) begin
                read_data_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int DEPTH = 64
) (
    input  wire             clock,
    input  wire             rst_n,
    input  rmii_pkg::word_t write_data,
    input  wire             write_enable,
    input  wire             read_enable,
    output rmii_pkg::word_t read_data,
    output logic            read_data_valid,
    output logic            full
);
    import rmii_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    word_t             mem [DEPTH];
    logic [ADDR_W-1:0] write_ptr;
    logic [ADDR_W-1:0] read_ptr;
    logic [ADDR_W:0]   count;
    logic              do_write;
    logic              do_read;

    assign full            = count == (ADDR_W + 1)'(DEPTH);
    assign read_data_valid = count != '0;
    assign do_write        = write_enable && !full;
    assign do_read         = read_enable && read_data_valid;

    // Head word is visible without a read
    assign read_data = mem[read_ptr];

    always_ff @(posedge clock) begin
        if (do_write)
            mem[write_ptr] <= write_data;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (do_write)
                write_ptr <= (write_ptr == ADDR_W'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
            if (do_read)
                read_ptr <= (read_ptr == ADDR_W'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rmii_byte_shipper.sv ====
`timescale 1ns/1ps
`default_nettype none

module rmii_byte_shipper (
    input  wire                          clock,
    input  wire                          rst_n,
    input  rmii_pkg::word_t              data,
    input  wire                          data_valid,
    output logic                         read_enable,
    output logic [rmii_pkg::DIBIT_W-1:0] rmii_transmit_data,
    output logic                         rmii_transmit_data_valid
);
    import rmii_pkg::*;

    localparam int COUNT_W = $clog2(IFG_BYTES > PREAMBLE_BYTES ? IFG_BYTES : PREAMBLE_BYTES);

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] PREAMBLE  = 3'd1;
    localparam logic [2:0] DELIMITER = 3'd2;
    localparam logic [2:0] PAYLOAD   = 3'd3;
    localparam logic [2:0] GAP       = 3'd4;

    logic [2:0]         state;
    logic [1:0]         dibit_count;
    logic [COUNT_W-1:0] byte_count;
    logic [BYTE_W-1:0]  shift_q;
    logic [BYTE_W-1:0]  next_byte;
    logic               last_q;
    logic               byte_done;
    logic               sending;

    assign byte_done = dibit_count == 2'd3;
    assign sending   = state == PREAMBLE || state == DELIMITER || state == PAYLOAD;

    // Pop as the next payload byte is loaded
    assign read_enable = byte_done && data_valid &&
                         (state == DELIMITER || (state == PAYLOAD && !last_q));

    always_comb begin
        if (state == PREAMBLE && byte_count == COUNT_W'(PREAMBLE_BYTES - 1))
            next_byte = SFD_BYTE;
        else if (state == PREAMBLE)
            next_byte = PREAMBLE_BYTE;
        else
            next_byte = data[BYTE_W-1:0];
    end

    always_ff @(posedge clock) begin
        rmii_transmit_data <= sending ? shift_q[DIBIT_W-1:0] : '0;
        if (state == IDLE)
            shift_q <= PREAMBLE_BYTE;
        else if (byte_done)
            shift_q <= next_byte;
        else
            shift_q <= shift_q >> DIBIT_W;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state                    <= IDLE;
            dibit_count              <= '0;
            byte_count               <= '0;
            last_q                   <= 1'b0;
            rmii_transmit_data_valid <= 1'b0;
        end else begin
            rmii_transmit_data_valid <= sending;
            dibit_count              <= dibit_count + 1'b1;
            case (state)
                IDLE: begin
                    dibit_count <= '0;
                    byte_count  <= '0;
                    if (data_valid)
                        state <= PREAMBLE;
                end
                PREAMBLE: begin
                    if (byte_done && byte_count == COUNT_W'(PREAMBLE_BYTES - 1)) begin
                        byte_count <= '0;
                        state      <= DELIMITER;
                    end else if (byte_done) begin
                        byte_count <= byte_count + 1'b1;
                    end
                end
                DELIMITER, PAYLOAD: begin
                    // No word ready means last sent or underrun
                    if (byte_done) begin
                        last_q <= data[BYTE_W];
                        state  <= read_enable ? PAYLOAD : GAP;
                    end
                end
                GAP: begin
                    if (byte_done && byte_count == COUNT_W'(IFG_BYTES - 1))
                        state <= IDLE;
                    else if (byte_done)
                        byte_count <= byte_count + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rmii_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module rmii_port #(
    parameter int RX_BUFFER_DEPTH = 64,
    parameter int TX_FIFO_DEPTH   = 64
) (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire [rmii_pkg::DIBIT_W-1:0]  rmii_receive_data,
    input  wire                          rmii_receive_data_enable,
    input  wire                          rmii_receive_data_error,
    input  rmii_pkg::word_t              transmit_data,
    input  wire                          transmit_data_enable,
    input  wire                          receive_data_enable,
    output rmii_pkg::word_t              receive_data,
    output logic                         receive_data_valid,
    output logic [rmii_pkg::DIBIT_W-1:0] rmii_transmit_data,
    output logic                         rmii_transmit_data_valid
);
    import rmii_pkg::*;

    ////////////////////
    // Receive path
    ////////////////////
    rmii_byte_if rx_bytes ();

    word_t checker_write_data;
    logic  checker_write_enable;
    logic  commit;
    logic  discard;
    logic  buffer_full;

    rmii_byte_packager u_rmii_byte_packager (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .byte_out                 (rx_bytes.source)
    );

    frame_checker u_frame_checker (
        .clock        (clock),
        .rst_n        (rst_n),
        .byte_in      (rx_bytes.sink),
        .full         (buffer_full),
        .write_data   (checker_write_data),
        .write_enable (checker_write_enable),
        .commit       (commit),
        .discard      (discard)
    );

    frame_buffer #(
        .DEPTH (RX_BUFFER_DEPTH)
    ) u_frame_buffer (
        .clock           (clock),
        .rst_n           (rst_n),
        .write_data      (checker_write_data),
        .write_enable    (checker_write_enable),
        .commit          (commit),
        .discard         (discard),
        .full            (buffer_full),
        .read_enable     (receive_data_enable),
        .read_data       (receive_data),
        .read_data_valid (receive_data_valid)
    );

    ////////////////////
    // Transmit path
    ////////////////////
    word_t tx_word;
    logic  tx_word_valid;
    logic  tx_read_enable;

    sync_fifo #(
        .DEPTH (TX_FIFO_DEPTH)
    ) tx_fifo (
        .clock           (clock),
        .rst_n           (rst_n),
        .write_data      (transmit_data),
        .write_enable    (transmit_data_enable),
        .read_enable     (tx_read_enable),
        .read_data       (tx_word),
        .read_data_valid (tx_word_valid),
        .full            ()
    );

    rmii_byte_shipper u_rmii_byte_shipper (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .data                     (tx_word),
        .data_valid               (tx_word_valid),
        .read_enable              (tx_read_enable),
        .rmii_transmit_data       (rmii_transmit_data),
        .rmii_transmit_data_valid (rmii_transmit_data_valid)
    );

endmodule

`default_nettype wire

// ==== tests/rmii_port_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rmii_port_assertions (
    input wire clock,
    input wire rst_n,
    input wire commit,
    input wire discard,
    input wire receive_data_valid,
    input wire rmii_transmit_data_valid
);

    logic [1:0] high_run;

    // Position of the line within its current byte
    always_ff @(posedge clock) begin
        if (!rst_n)
            high_run <= '0;
        else if (rmii_transmit_data_valid)
            high_run <= high_run + 1'b1;
        else
            high_run <= '0;
    end

    valid_low_after_reset: assert property (
        @(posedge clock) $rose(rst_n) |-> !receive_data_valid && !rmii_transmit_data_valid
    ) else $error("valid outputs high right after reset");

    single_decision: assert property (
        @(posedge clock) disable iff (!rst_n)
        (commit || discard) |-> !(commit && discard) ##1 !(commit || discard)
    ) else $error("commit or discard overlapped or lasted more than one cycle");

    whole_bytes_sent: assert property (
        @(posedge clock) disable iff (!rst_n)
        $fell(rmii_transmit_data_valid) |-> high_run == 2'd0
    ) else $error("transmit valid ended partway through a byte");

endmodule

bind rmii_port rmii_port_assertions u_rmii_port_assertions (
    .clock                    (clock),
    .rst_n                    (rst_n),
    .commit                   (commit),
    .discard                  (discard),
    .receive_data_valid       (receive_data_valid),
    .rmii_transmit_data_valid (rmii_transmit_data_valid)
);

`default_nettype wire

// ==== tests/rmii_port_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rmii_port_tb;
    import rmii_pkg::*;

    localparam logic [1:0] RX       = 2'd0;
    localparam logic [1:0] TX       = 2'd1;
    localparam logic [1:0] TX_PAIR  = 2'd2;
    localparam logic [1:0] LOOPBACK = 2'd3;
    localparam int         NUM_TESTS = 8;

    typedef logic [BYTE_W-1:0] byte_q_t [$];

    typedef struct packed {
        logic [1:0] mode;
        logic [7:0] length;
        logic [7:0] seed_offset;
        logic       bad_fcs;
        logic       rx_error;
        logic       deliver;
    } row_t;

    ////////////////////
    // Stimulus table
    ////////////////////
    string test_names [NUM_TESTS] = '{
        "rx_good", "rx_bad_fcs", "rx_after_bad", "rx_error",
        "rx_single_byte", "tx_single", "tx_back_to_back", "loopback"
    };

    row_t rows [NUM_TESTS] = '{
        '{RX,       8'd24, 8'd0, 1'b0, 1'b0, 1'b1},
        '{RX,       8'd30, 8'd1, 1'b1, 1'b0, 1'b0},
        '{RX,       8'd17, 8'd2, 1'b0, 1'b0, 1'b1},
        '{RX,       8'd20, 8'd3, 1'b0, 1'b1, 1'b0},
        '{RX,       8'd1,  8'd4, 1'b0, 1'b0, 1'b1},
        '{TX,       8'd24, 8'd5, 1'b0, 1'b0, 1'b0},
        '{TX_PAIR,  8'd16, 8'd6, 1'b0, 1'b0, 1'b0},
        '{LOOPBACK, 8'd20, 8'd7, 1'b0, 1'b0, 1'b1}
    };

    logic               clock = 1'b0;
    logic               rst_n;
    logic [DIBIT_W-1:0] rmii_receive_data;
    logic               rmii_receive_data_enable;
    logic               rmii_receive_data_error;
    word_t              transmit_data;
    logic               transmit_data_enable;
    logic               receive_data_enable;
    word_t              receive_data;
    logic               receive_data_valid;
    logic [DIBIT_W-1:0] rmii_transmit_data;
    logic               rmii_transmit_data_valid;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    // Monitor records, read through indices owned by the main process
    word_t             rx_words [$];
    logic [BYTE_W-1:0] tx_bytes [$];
    int                tx_frame_dibits [$];
    int                tx_gaps [$];
    int                rx_index;
    int                tx_byte_index;
    int                tx_frame_index;
    logic [BYTE_W-1:0] tx_shift;
    int                tx_dibits;
    int                low_run;
    logic              tx_in_frame;

    rmii_port #(
        .RX_BUFFER_DEPTH (64),
        .TX_FIFO_DEPTH   (64)
    ) u_rmii_port (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .transmit_data            (transmit_data),
        .transmit_data_enable     (transmit_data_enable),
        .receive_data_enable      (receive_data_enable),
        .receive_data             (receive_data),
        .receive_data_valid       (receive_data_valid),
        .rmii_transmit_data       (rmii_transmit_data),
        .rmii_transmit_data_valid (rmii_transmit_data_valid)
    );

    always #5 clock = ~clock;

    function automatic int timeout_cycles();
        int total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            total += 4 * (int'(rows[t].length) + 12 + 12);
        return 2 * total;
    endfunction

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > timeout_cycles()) begin
            $display("timeout after %0d cycles with tests still waiting", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Host pops whenever a word is shown
    always @(negedge clock) begin
        if (rst_n && receive_data_valid && receive_data_enable)
            rx_words.push_back(receive_data);
    end

    ////////////////////
    // Transmit decoder
    ////////////////////
    always @(negedge clock) begin
        if (!rst_n) begin
            tx_dibits   = 0;
            low_run     = 0;
            tx_in_frame = 1'b0;
        end else if (rmii_transmit_data_valid) begin
            if (!tx_in_frame)
                tx_gaps.push_back(low_run);
            tx_in_frame = 1'b1;
            low_run     = 0;
            tx_shift    = {rmii_transmit_data, tx_shift[BYTE_W-1:DIBIT_W]};
            tx_dibits   = tx_dibits + 1;
            if (tx_dibits % 4 == 0)
                tx_bytes.push_back(tx_shift);
        end else begin
            if (tx_in_frame)
                tx_frame_dibits.push_back(tx_dibits);
            tx_in_frame = 1'b0;
            tx_dibits   = 0;
            low_run     = low_run + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic byte_q_t append_fcs(input byte_q_t payload, input logic corrupt);
        byte_q_t     frame;
        logic [31:0] crc;
        logic [31:0] fcs;
        frame = payload;
        crc   = CRC_INIT;
        foreach (payload[i])
            crc = crc32_next(crc, payload[i]);
        fcs = ~crc ^ (corrupt ? 32'h0000_0200 : 32'h0);
        for (int k = 0; k < FCS_BYTES; k++)
            frame.push_back(fcs[8*k +: 8]);
        return frame;
    endfunction

    task automatic drive_byte(input logic [BYTE_W-1:0] value, input logic error_flag);
        for (int d = 0; d < 4; d++) begin
            @(posedge clock);
            #1;
            rmii_receive_data        = value[DIBIT_W*d +: DIBIT_W];
            rmii_receive_data_enable = 1'b1;
            rmii_receive_data_error  = error_flag && d == 1;
        end
    endtask

    task automatic send_rx_frame(input byte_q_t frame, input int error_byte);
        for (int i = 0; i < PREAMBLE_BYTES; i++)
            drive_byte(PREAMBLE_BYTE, 1'b0);
        drive_byte(SFD_BYTE, 1'b0);
        foreach (frame[i])
            drive_byte(frame[i], i == error_byte);
        @(posedge clock);
        #1;
        rmii_receive_data        = '0;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
    endtask

    task automatic write_tx_frame(input byte_q_t frame);
        foreach (frame[i]) begin
            @(posedge clock);
            #1;
            transmit_data        = {i == frame.size() - 1, frame[i]};
            transmit_data_enable = 1'b1;
        end
        @(posedge clock);
        #1;
        transmit_data_enable = 1'b0;
    endtask

    // Copies the transmit pins onto the receive pins for one frame
    task automatic loop_back_frame();
        logic started;
        started = 1'b0;
        while (!(started && !rmii_receive_data_enable)) begin
            @(posedge clock);
            #1;
            rmii_receive_data        = rmii_transmit_data;
            rmii_receive_data_enable = rmii_transmit_data_valid;
            started                  = started || rmii_transmit_data_valid;
        end
    endtask

    task automatic wait_decision(output logic committed);
        do
            @(negedge clock);
        while (!u_rmii_port.commit && !u_rmii_port.discard);
        committed = u_rmii_port.commit;
    endtask

    task automatic check_rx(input string name, input byte_q_t payload);
        while (rx_words.size() < rx_index + payload.size())
            @(negedge clock);
        foreach (payload[i]) begin
            check(name, 32'({i == payload.size() - 1, payload[i]}), 32'(rx_words[rx_index]));
            rx_index++;
        end
    endtask

    task automatic check_tx(input string name, input byte_q_t payload);
        byte_q_t expected;
        for (int i = 0; i < PREAMBLE_BYTES; i++)
            expected.push_back(PREAMBLE_BYTE);
        expected.push_back(SFD_BYTE);
        foreach (payload[i])
            expected.push_back(payload[i]);
        while (tx_frame_dibits.size() <= tx_frame_index)
            @(negedge clock);
        check(name, 32'(4 * expected.size()), 32'(tx_frame_dibits[tx_frame_index]));
        if (tx_gaps[tx_frame_index] < 4 * IFG_BYTES) begin
            errors++;
            $display("%s: only %0d idle cycles before the frame", name,
                     tx_gaps[tx_frame_index]);
        end
        foreach (expected[i])
            check(name, 32'(expected[i]), 32'(tx_bytes[tx_byte_index + i]));
        tx_byte_index += tx_frame_dibits[tx_frame_index] / 4;
        tx_frame_index++;
    endtask

    initial begin
        logic    committed;
        byte_q_t payload;
        byte_q_t second;
        byte_q_t frame;
        int      row_errors;
        rst_n                    = 1'b0;
        rmii_receive_data        = '0;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        transmit_data            = '0;
        transmit_data_enable     = 1'b0;
        receive_data_enable      = 1'b0;
        repeat (16) @(posedge clock);
        #1;
        rst_n               = 1'b1;
        receive_data_enable = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            row_errors = errors;
            seed       = 32'h8997 + rows[t].seed_offset;
            payload.delete();
            for (int i = 0; i < int'(rows[t].length); i++)
                payload.push_back(8'($random(seed)));
            frame = append_fcs(payload, rows[t].bad_fcs);
            case (rows[t].mode)
                RX: begin
                    send_rx_frame(frame, rows[t].rx_error ? payload.size() / 2 : -1);
                    wait_decision(committed);
                    check(test_names[t], 32'(rows[t].deliver), 32'(committed));
                    if (rows[t].deliver) begin
                        check_rx(test_names[t], payload);
                    end else begin
                        repeat (4) @(negedge clock);
                        check(test_names[t], 32'(rx_index), 32'(rx_words.size()));
                    end
                end
                TX: begin
                    write_tx_frame(payload);
                    check_tx(test_names[t], payload);
                end
                TX_PAIR: begin
                    second.delete();
                    for (int i = 0; i < int'(rows[t].length) / 2; i++)
                        second.push_back(8'($random(seed)));
                    write_tx_frame(payload);
                    write_tx_frame(second);
                    check_tx(test_names[t], payload);
                    check_tx(test_names[t], second);
                end
                LOOPBACK: begin
                    write_tx_frame(frame);
                    loop_back_frame();
                    wait_decision(committed);
                    check(test_names[t], 32'(1), 32'(committed));
                    check_rx(test_names[t], payload);
                    check_tx(test_names[t], frame);
                end
            endcase
            $display("%s: %0d errors", test_names[t], errors - row_errors);
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/rmii_pkg.sv
rtl/rmii_byte_if.sv
rtl/rmii_byte_packager.sv
rtl/frame_checker.sv
rtl/frame_buffer.sv
rtl/sync_fifo.sv
rtl/rmii_byte_shipper.sv
rtl/rmii_port.sv
tests/rmii_port_assertions.sv
tests/rmii_port_tb.sv

// ==== Makefile ====
TOP = rmii_port_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf obj_dir
